// ==== redund_pkg.sv ====
`default_nettype none

package redund_pkg;

	localparam int ID_W  = 8;
	localparam int IDX_W = 6; // enough for MAX_LEN 64

	// r=1, r=3, r=5 or no output at all
	typedef enum logic [1:0] {
		MODE_R1  = 2'd0,
		MODE_R3  = 2'd1,
		MODE_R5  = 2'd2,
		MODE_OFF = 2'd3
	} mode_e;

	// one tracked frame byte
	typedef struct packed {
		logic [7:0]       data;
		logic [IDX_W-1:0] idx;
		logic [ID_W-1:0]  id;
		logic             first;
		logic             last;
		logic             en;
	} beat_t;

	function automatic mode_e decode_mode(input logic [7:0] redundancy);
		mode_e m;
		case (redundancy)
			8'd1: m = MODE_R1;
			8'd3: m = MODE_R3;
			8'd5: m = MODE_R5;
			default: m = MODE_OFF;
		endcase
		return m;
	endfunction

	// copies held in buffers before the deciding one (r-1)
	function automatic logic [2:0] stored_copies(input mode_e m);
		logic [2:0] n;
		case (m)
			MODE_R3: n = 3'd2;
			MODE_R5: n = 3'd4;
			default: n = 3'd0;
		endcase
		return n;
	endfunction

endpackage

`default_nettype wire

// ==== frame_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_tracker import redund_pkg::*; #(
	parameter int ID_OFFSET = 0
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic [7:0] rxd,
	input  wire logic       rxen,
	output beat_t           beat
);

	// stage 0 is the input register, the rest is the delay line
	localparam int DEPTH = ID_OFFSET + 2;

	beat_t pipe [DEPTH];
	logic [ID_W-1:0] id_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i].en <= 1'b0;
			end
		end else begin
			pipe[0].data  <= rxd;
			pipe[0].en    <= rxen;
			pipe[0].first <= rxen && !pipe[0].en; // rising edge of rxen
			pipe[0].idx   <= pipe[0].en ? pipe[0].idx + 1'b1 : '0;
			pipe[0].id    <= '0; // filled in at the output
			pipe[0].last  <= 1'b0;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	// id byte reaches stage 0 exactly when byte 0 leaves the line
	always_ff @(posedge clk) begin
		if (pipe[0].en && pipe[0].idx == IDX_W'(ID_OFFSET))
			id_q <= pipe[0].data;
	end

	always_comb begin
		beat      = pipe[DEPTH-1];
		beat.id   = id_q;
		// successor stage empty means this is the final byte
		beat.last = pipe[DEPTH-1].en && !pipe[DEPTH-2].en;
	end

endmodule

`default_nettype wire

// ==== copy_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module copy_ram import redund_pkg::*; #(
	parameter int MAX_LEN = 64
) (
	input  wire logic             clk,
	input  wire logic             we,
	input  wire logic [IDX_W-1:0] waddr,
	input  wire logic [7:0]       wdata,
	input  wire logic [IDX_W-1:0] raddr,
	output logic      [7:0]       rdata
);

	logic [7:0] mem [MAX_LEN];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // registered read
	end

endmodule

`default_nettype wire

// ==== copy_voter.sv ====
`timescale 1ns/100ps
`default_nettype none

module copy_voter import redund_pkg::*; #(
	parameter int MAX_LEN = 64
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire mode_e      mode,
	input  wire beat_t      beat,
	output logic      [7:0] vote_data,
	output logic            vote_en
);

	localparam int NBUF = 4;

	logic [2:0]      need;
	logic            active;
	logic [2:0]      copy_q;
	logic [2:0]      copy_cur;
	logic [ID_W-1:0] gid;
	logic            gvalid;
	logic            deciding;
	logic [NBUF-1:0] we;
	logic [7:0]      rdata [NBUF];
	logic [7:0]      live_q;
	logic            en_q;
	logic            r5_q;

	function automatic logic [7:0] maj3(input logic [7:0] a, b, c);
		return (a & b) | (a & c) | (b & c);
	endfunction

	// 3 of 5 per bit
	function automatic logic [7:0] maj5(input logic [7:0] a, b, c, d, e);
		logic [2:0] n;
		logic [7:0] m;
		for (int k = 0; k < 8; k++) begin
			n = 3'(a[k]) + 3'(b[k]) + 3'(c[k]) + 3'(d[k]) + 3'(e[k]);
			m[k] = n >= 3'd3;
		end
		return m;
	endfunction

	assign need   = stored_copies(mode);
	assign active = need != 3'd0;

	// copy number of the frame on the beat, decided on its first byte
	always_comb begin
		if (beat.first)
			copy_cur = (gvalid && beat.id == gid) ? copy_q + 3'd1 : 3'd0;
		else
			copy_cur = copy_q;
	end

	assign deciding = active && copy_cur == need;

	always_ff @(posedge clk) begin
		if (rst) begin
			copy_q <= 3'd0;
			gvalid <= 1'b0;
		end else if (beat.en) begin
			if (beat.first) begin
				gid    <= beat.id;
				gvalid <= 1'b1;
			end
			copy_q <= copy_cur;
			if (beat.last && deciding) begin // group done, same id starts over
				copy_q <= 3'd0;
				gvalid <= 1'b0;
			end
		end
	end

	for (genvar i = 0; i < NBUF; i++) begin : g_buf
		assign we[i] = active && beat.en && copy_cur == 3'(i) && copy_cur < need;

		copy_ram #(
			.MAX_LEN(MAX_LEN)
		) u_ram (
			.clk  (clk),
			.we   (we[i]),
			.waddr(beat.idx),
			.wdata(beat.data),
			.raddr(beat.idx), // read every beat, used on the deciding copy
			.rdata(rdata[i])
		);
	end

	// live byte lines up with the ram read data
	always_ff @(posedge clk) begin
		if (rst)
			en_q <= 1'b0;
		else
			en_q <= beat.en && deciding;
		live_q <= beat.data;
		r5_q   <= mode == MODE_R5;
	end

	assign vote_en = en_q;

	always_comb begin
		if (r5_q)
			vote_data = maj5(rdata[0], rdata[1], rdata[2], rdata[3], live_q);
		else
			vote_data = maj3(rdata[0], rdata[1], live_q);
	end

endmodule

`default_nettype wire

// ==== dup_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module dup_filter import redund_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       active,
	input  wire beat_t      beat,
	output logic      [7:0] pass_data,
	output logic            pass_en
);

	logic [ID_W-1:0] prev_id;
	logic            prev_valid;
	logic            fwd_q;
	logic            fwd_cur;

	// new id or nothing seen yet
	always_comb begin
		if (beat.first)
			fwd_cur = !prev_valid || beat.id != prev_id;
		else
			fwd_cur = fwd_q;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prev_valid <= 1'b0;
			fwd_q      <= 1'b0;
		end else if (beat.en) begin
			if (beat.first) begin
				prev_id    <= beat.id;
				prev_valid <= 1'b1;
			end
			fwd_q <= fwd_cur && !beat.last;
		end
	end

	// history kept even while another mode is selected
	always_ff @(posedge clk) begin
		if (rst)
			pass_en <= 1'b0;
		else
			pass_en <= beat.en && fwd_cur && active;
		pass_data <= beat.data;
	end

endmodule

`default_nettype wire

// ==== redund_merge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module redund_merge_top import redund_pkg::*; #(
	parameter int ID_OFFSET = 0,
	parameter int MAX_LEN   = 64
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic [7:0] rxd,
	input  wire logic       rxen,
	input  wire logic [7:0] redundancy,
	output logic      [7:0] data_out,
	output logic            en_out
);

	mode_e      mode;
	beat_t      beat;
	logic [7:0] vote_data;
	logic       vote_en;
	logic [7:0] pass_data;
	logic       pass_en;
	logic [7:0] sel_data;
	logic       sel_en;

	assign mode = decode_mode(redundancy);

	frame_tracker #(
		.ID_OFFSET(ID_OFFSET)
	) u_tracker (
		.clk (clk),
		.rst (rst),
		.rxd (rxd),
		.rxen(rxen),
		.beat(beat)
	);

	copy_voter #(
		.MAX_LEN(MAX_LEN)
	) u_voter (
		.clk      (clk),
		.rst      (rst),
		.mode     (mode),
		.beat     (beat),
		.vote_data(vote_data),
		.vote_en  (vote_en)
	);

	dup_filter u_filter (
		.clk      (clk),
		.rst      (rst),
		.active   (mode == MODE_R1),
		.beat     (beat),
		.pass_data(pass_data),
		.pass_en  (pass_en)
	);

	always_comb begin
		if (mode == MODE_R1) begin
			sel_data = pass_data;
			sel_en   = pass_en;
		end else begin
			sel_data = vote_data;
			sel_en   = vote_en;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			en_out <= 1'b0;
		else
			en_out <= sel_en && mode != MODE_OFF; // nothing out for r not 1/3/5
		data_out <= sel_data;
	end

endmodule

`default_nettype wire

// ==== redund_merge_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module redund_merge_props import redund_pkg::*; (
	input wire logic  clk,
	input wire logic  rst,
	input wire logic  en_out,
	input wire beat_t beat,
	input wire mode_e mode
);

	int err_cnt = 0; // assertion failures so far

	// output register clears on a reset cycle
	a_reset_quiet: assert property (@(posedge clk) rst |=> !en_out)
		else begin
			$error("en_out high after a reset cycle");
			err_cnt++;
		end

	// id is latched before byte 0 leaves the tracker and holds for the frame
	a_id_steady: assert property (@(posedge clk) disable iff (rst)
		beat.en && !beat.first |-> beat.id == $past(beat.id))
		else begin
			$error("beat id changed in the middle of a frame");
			err_cnt++;
		end

	a_off_silent: assert property (@(posedge clk) disable iff (rst)
		mode == MODE_OFF |-> !en_out)
		else begin
			$error("en_out high while redundancy mode is off");
			err_cnt++;
		end

endmodule

bind redund_merge_top redund_merge_props u_props (
	.clk   (clk),
	.rst   (rst),
	.en_out(en_out),
	.beat  (beat),
	.mode  (mode)
);

`default_nettype wire

// ==== tb_redund_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_redund_merge;

	localparam int ID_OFFSET    = 2;
	localparam int MAX_LEN      = 64;
	localparam int CLK_NS       = 8;
	localparam int FRAME_LEN    = 20;
	localparam int SHORT_LEN    = 12;
	localparam int FRAMES_SENT  = 29; // all frames of all tests
	localparam int DRAIN_CYCLES = ID_OFFSET + 8;
	localparam int WAIT_CYCLES  = 6 * (MAX_LEN + 2);
	localparam int WATCHDOG_NS  = FRAMES_SENT * (MAX_LEN + 2) * CLK_NS + 2000;

	typedef logic [7:0] byte_q_t [$];

	logic       clk;
	logic       rst;
	logic [7:0] rxd;
	logic       rxen;
	logic [7:0] redundancy;
	logic [7:0] data_out;
	logic       en_out;

	logic [7:0] rx_data [$]; // received bytes, frames back to back
	int         rx_start [$];
	int         rx_len [$];
	int         cur_len = 0;
	int         mismatch_cnt = 0;
	int         fail_cnt = 0;

	redund_merge_top #(
		.ID_OFFSET(ID_OFFSET),
		.MAX_LEN  (MAX_LEN)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.rxd       (rxd),
		.rxen      (rxen),
		.redundancy(redundancy),
		.data_out  (data_out),
		.en_out    (en_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	// one entry per run of en_out
	always @(posedge clk) begin
		if (en_out) begin
			if (cur_len == 0)
				rx_start.push_back(rx_data.size());
			rx_data.push_back(data_out);
			cur_len = cur_len + 1;
		end else if (cur_len != 0) begin
			rx_len.push_back(cur_len);
			cur_len = 0;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
			mismatch_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int expected);
		if (rx_len.size() != expected) begin
			$display("MISMATCH %s frame count: expected %0d, actual %0d",
				name, expected, rx_len.size());
			mismatch_cnt++;
		end
	endtask

	task automatic check_frame(input string name, input int k, input byte_q_t exp);
		int n;
		if (k >= rx_len.size()) begin
			$display("%s: output frame %0d never arrived", name, k);
			fail_cnt++;
		end else begin
			if (rx_len[k] != exp.size()) begin
				$display("%s: output frame %0d is %0d bytes long instead of %0d",
					name, k, rx_len[k], exp.size());
				fail_cnt++;
			end
			n = (rx_len[k] < exp.size()) ? rx_len[k] : exp.size();
			for (int i = 0; i < n; i++)
				check_byte($sformatf("%s byte %0d", name, i), exp[i], rx_data[rx_start[k] + i]);
		end
	endtask

	function automatic byte_q_t make_frame(input logic [7:0] id, input int len);
		byte_q_t f;
		for (int i = 0; i < len; i++)
			f.push_back((i == ID_OFFSET) ? id : 8'($urandom));
		return f;
	endfunction

	task automatic send_frame(input byte_q_t f);
		foreach (f[i]) begin
			@(posedge clk);
			rxd  <= f[i];
			rxen <= 1'b1;
		end
		repeat (2) begin
			@(posedge clk);
			rxen <= 1'b0;
		end
	endtask

	task automatic send_copies(input byte_q_t f, input int n);
		repeat (n) send_frame(f);
	endtask

	// only called while the stream is idle
	task automatic set_redundancy(input logic [7:0] r);
		@(posedge clk);
		redundancy <= r;
		@(posedge clk);
	endtask

	task automatic wait_frames(input string name, input int n);
		int cycles;
		cycles = 0;
		while (rx_len.size() < n && cycles < WAIT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (rx_len.size() < n) begin
			$display("%s: timed out waiting for %0d output frames", name, n);
			fail_cnt++;
		end
		repeat (DRAIN_CYCLES) @(posedge clk);
	endtask

	task automatic test_r1_dedup();
		byte_q_t f5;
		byte_q_t f7;
		int base;
		base = rx_len.size();
		set_redundancy(8'd1);
		f5 = make_frame(8'h05, FRAME_LEN);
		f7 = make_frame(8'h07, SHORT_LEN);
		send_copies(f5, 2);
		send_frame(f7);
		send_frame(f5);
		wait_frames("r1_dedup", base + 3);
		check_count("r1_dedup", base + 3);
		check_frame("r1_dedup", base, f5);
		check_frame("r1_dedup", base + 1, f7);
		check_frame("r1_dedup", base + 2, f5);
	endtask

	task automatic test_r3_repair();
		byte_q_t clean;
		byte_q_t c1;
		byte_q_t c2;
		int base;
		base = rx_len.size();
		set_redundancy(8'd3);
		clean = make_frame(8'h21, FRAME_LEN);
		c1 = clean;
		c1[4] = c1[4] ^ 8'hff;
		c2 = clean;
		c2[9] = c2[9] ^ 8'hff; // deciding copy is the bad one here
		send_frame(clean);
		send_frame(c1);
		send_frame(c2);
		wait_frames("r3_repair", base + 1);
		check_count("r3_repair", base + 1);
		check_frame("r3_repair", base, clean);
	endtask

	task automatic test_r5_two_bad();
		byte_q_t clean;
		byte_q_t bad;
		int base;
		base = rx_len.size();
		set_redundancy(8'd5);
		clean = make_frame(8'h33, FRAME_LEN);
		bad = clean;
		bad[6] = bad[6] ^ 8'h08;
		send_frame(clean);
		send_frame(bad);
		send_copies(clean, 2);
		send_frame(bad);
		wait_frames("r5_two_bad", base + 1);
		check_count("r5_two_bad", base + 1);
		check_frame("r5_two_bad", base, clean);
	endtask

	task automatic test_incomplete_group();
		byte_q_t f8;
		byte_q_t f9;
		int base;
		base = rx_len.size();
		set_redundancy(8'd3);
		f8 = make_frame(8'h08, SHORT_LEN);
		f9 = make_frame(8'h09, FRAME_LEN);
		send_copies(f8, 2);
		send_copies(f9, 3);
		wait_frames("incomplete_group", base + 1);
		check_count("incomplete_group", base + 1);
		check_frame("incomplete_group", base, f9);
	endtask

	task automatic test_back_to_back_off();
		byte_q_t g0;
		byte_q_t g1;
		byte_q_t g2;
		byte_q_t g_off;
		int base;
		base = rx_len.size();
		set_redundancy(8'd3);
		g0 = make_frame(8'h41, FRAME_LEN);
		g1 = make_frame(8'h42, SHORT_LEN);
		g2 = make_frame(8'h43, FRAME_LEN);
		send_copies(g0, 3);
		send_copies(g1, 3);
		send_copies(g2, 3);
		wait_frames("back_to_back", base + 3);
		check_count("back_to_back", base + 3);
		check_frame("back_to_back", base, g0);
		check_frame("back_to_back", base + 1, g1);
		check_frame("back_to_back", base + 2, g2);
		set_redundancy(8'd4); // not 1/3/5, expect silence
		g_off = make_frame(8'h44, FRAME_LEN);
		send_copies(g_off, 3);
		repeat (FRAME_LEN + ID_OFFSET + DRAIN_CYCLES) @(posedge clk);
		check_count("mode_off", base + 3);
	endtask

	initial begin
		void'($urandom(32'h4fa14c27));
		rst        = 1'b1;
		rxd        = 8'h00;
		rxen       = 1'b0;
		redundancy = 8'd1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);
		test_r1_dedup();
		test_r3_repair();
		test_r5_two_bad();
		test_incomplete_group();
		test_back_to_back_off();
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_cnt, fail_cnt, dut0.u_props.err_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0 && dut0.u_props.err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
redund_pkg.sv
frame_tracker.sv
copy_ram.sv
copy_voter.sv
dup_filter.sv
redund_merge_top.sv
redund_merge_props.sv
tb_redund_merge.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_redund_merge
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
